// ==== verilog/matrix_pkg.sv ====
package matrix_pkg;

	// panel geometry, two halves of 16 lines by 64 columns
	localparam int num_cols = 64;
	localparam int num_lines = 16;
	localparam int col_w = 6;
	localparam int line_w = 4;
	localparam int pix_w = 10;

	// external byte memory map
	localparam int addr_w = 16;
	localparam logic [addr_w-1:0] upper_base = 16'h0000;
	localparam logic [addr_w-1:0] lower_base = 16'h0400;
	localparam logic [addr_w-1:0] brightness_addr = 16'h0800;

	localparam logic [7:0] brightness_min = 8'd1;
	localparam logic [7:0] brightness_max = 8'd8;
	localparam logic [7:0] brightness_reset = 8'd4;

	// display period per phase, index 0 in the low bits
	localparam int cnt_w = 12;
	localparam logic [2:0][cnt_w-1:0] phase_period = {12'd2048, 12'd1024, 12'd512};

	typedef enum logic [1:0] {
		phase_0,
		phase_1,
		phase_2
	} phase_t;

	typedef enum logic [3:0] {
		ld_bright_addr, ld_bright_hi, ld_bright_sample, ld_bright_lo,
		ld_upper_addr, ld_upper_hi, ld_upper_sample, ld_upper_lo,
		ld_lower_addr, ld_lower_hi, ld_lower_sample, ld_lower_lo,
		ld_write
	} loader_state_t;

	typedef enum logic [2:0] {
		sc_set,
		sc_clk_hi,
		sc_clk_lo,
		sc_latch,
		sc_wait
	} scan_state_t;

endpackage

// ==== verilog/frame_loader.sv ====
module frame_loader (
	input logic display_driver_clk,
	input logic arst_n,
	input logic [7:0] input_byte,
	output logic [matrix_pkg::addr_w-1:0] mem_addr,
	output logic ramclk,
	output logic wr_en,
	output logic [matrix_pkg::pix_w-1:0] wr_addr,
	output logic [5:0] wr_upper,
	output logic [5:0] wr_lower,
	output logic [7:0] brightness
);
	import matrix_pkg::*;

	loader_state_t state;
	logic [pix_w-1:0] pix_cnt;

	always_ff @(posedge display_driver_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= ld_bright_addr;
			mem_addr <= '0;
			ramclk <= 1'b0;
			pix_cnt <= '0;
			brightness <= brightness_reset;
		end
		else
		begin
			case (state)
				ld_bright_addr:
				begin
					mem_addr <= brightness_addr;
					state <= ld_bright_hi;
				end
				ld_bright_hi:
				begin
					ramclk <= 1'b1;
					state <= ld_bright_sample;
				end
				ld_bright_sample:
				begin
					// out of range values leave the old brightness
					if (input_byte >= brightness_min && input_byte <= brightness_max)
						brightness <= input_byte;
					state <= ld_bright_lo;
				end
				ld_bright_lo:
				begin
					ramclk <= 1'b0;
					state <= ld_upper_addr;
				end
				ld_upper_addr:
				begin
					mem_addr <= upper_base + addr_w'(pix_cnt);
					state <= ld_upper_hi;
				end
				ld_upper_hi:
				begin
					ramclk <= 1'b1;
					state <= ld_upper_sample;
				end
				ld_upper_sample:
					state <= ld_upper_lo;
				ld_upper_lo:
				begin
					ramclk <= 1'b0;
					state <= ld_lower_addr;
				end
				ld_lower_addr:
				begin
					mem_addr <= lower_base + addr_w'(pix_cnt);
					state <= ld_lower_hi;
				end
				ld_lower_hi:
				begin
					ramclk <= 1'b1;
					state <= ld_lower_sample;
				end
				ld_lower_sample:
					state <= ld_lower_lo;
				ld_lower_lo:
				begin
					ramclk <= 1'b0;
					state <= ld_write;
				end
				ld_write:
				begin
					pix_cnt <= pix_cnt + 1'b1;
					// frame done, fetch brightness again
					if (pix_cnt == '1)
						state <= ld_bright_addr;
					else
						state <= ld_upper_addr;
				end
				default:
					state <= ld_bright_addr;
			endcase
		end
	end

	always_ff @(posedge display_driver_clk)
	begin
		if (state == ld_upper_sample)
			wr_upper <= input_byte[5:0];
		if (state == ld_lower_sample)
			wr_lower <= input_byte[5:0];
	end

	assign wr_en = (state == ld_write);
	assign wr_addr = pix_cnt;

	a_addr_stable: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		ramclk |-> $stable(mem_addr))
		else $error("mem_addr changed while ramclk high");

endmodule

// ==== verilog/frame_buffer.sv ====
module frame_buffer (
	input logic display_driver_clk,
	input logic wr_en,
	input logic [matrix_pkg::pix_w-1:0] wr_addr,
	input logic [5:0] wr_upper,
	input logic [5:0] wr_lower,
	input logic [matrix_pkg::line_w-1:0] rd_line,
	input logic [matrix_pkg::col_w-1:0] rd_col,
	input matrix_pkg::phase_t rd_phase,
	output logic r1,
	output logic g1,
	output logic b1,
	output logic r2,
	output logic g2,
	output logic b2
);
	import matrix_pkg::*;

	// upper half in the low six bits
	logic [11:0] pixel_mem [num_cols*num_lines];
	logic [pix_w-1:0] rd_addr;
	logic [11:0] rd_word;

	function automatic logic plane_bit(input logic [1:0] comp, input phase_t phase);
		case (phase)
			phase_0: plane_bit = comp[0];
			phase_1: plane_bit = comp[1];
			default: plane_bit = &comp;
		endcase
	endfunction

	always_ff @(posedge display_driver_clk)
	begin
		if (wr_en)
			pixel_mem[wr_addr] <= {wr_lower, wr_upper};
	end

	assign rd_addr = {rd_line, rd_col};
	assign rd_word = pixel_mem[rd_addr];

	assign r1 = plane_bit(rd_word[1:0], rd_phase);
	assign g1 = plane_bit(rd_word[3:2], rd_phase);
	assign b1 = plane_bit(rd_word[5:4], rd_phase);
	assign r2 = plane_bit(rd_word[7:6], rd_phase);
	assign g2 = plane_bit(rd_word[9:8], rd_phase);
	assign b2 = plane_bit(rd_word[11:10], rd_phase);

endmodule

// ==== verilog/scan_sequencer.sv ====
module scan_sequencer (
	input logic display_driver_clk,
	input logic arst_n,
	input logic r1,
	input logic g1,
	input logic b1,
	input logic r2,
	input logic g2,
	input logic b2,
	input logic lit,
	input logic done,
	output logic [matrix_pkg::line_w-1:0] rd_line,
	output logic [matrix_pkg::col_w-1:0] rd_col,
	output matrix_pkg::phase_t rd_phase,
	output logic start,
	output logic [matrix_pkg::line_w-1:0] m_line_addr,
	output logic m_r1,
	output logic m_g1,
	output logic m_b1,
	output logic m_r2,
	output logic m_g2,
	output logic m_b2,
	output logic m_latch,
	output logic m_oe,
	output logic m_clk
);
	import matrix_pkg::*;

	scan_state_t state, state_next;
	logic [col_w-1:0] col, col_next;
	logic [line_w-1:0] line, line_next;
	phase_t phase, phase_next;

	always_comb
	begin
		state_next = state;
		col_next = col;
		line_next = line;
		phase_next = phase;
		case (state)
			sc_set:
				state_next = sc_clk_hi;
			sc_clk_hi:
				state_next = sc_clk_lo;
			sc_clk_lo:
			begin
				// column wraps to 0 after the last one
				col_next = col + 1'b1;
				if (col == col_w'(num_cols - 1))
					state_next = sc_latch;
				else
					state_next = sc_set;
			end
			sc_latch:
				state_next = sc_wait;
			sc_wait:
			begin
				if (done)
				begin
					state_next = sc_set;
					if (phase == phase_2)
					begin
						phase_next = phase_0;
						line_next = line + 1'b1;
					end
					else
						phase_next = phase_t'(phase + 2'd1);
				end
			end
			default:
				state_next = sc_set;
		endcase
	end

	always_ff @(posedge display_driver_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= sc_set;
			col <= '0;
			line <= '0;
			phase <= phase_0;
			m_line_addr <= '0;
			{m_r1, m_g1, m_b1, m_r2, m_g2, m_b2} <= '0;
		end
		else
		begin
			state <= state_next;
			col <= col_next;
			line <= line_next;
			phase <= phase_next;
			if (state_next == sc_latch)
				m_line_addr <= line;
			// colours change on entry to SET, one cycle ahead of m_clk
			if (state_next == sc_set)
				{m_r1, m_g1, m_b1, m_r2, m_g2, m_b2} <= {r1, g1, b1, r2, g2, b2};
		end
	end

	// buffer is addressed with the pixel about to be shown
	assign rd_line = line_next;
	assign rd_col = col_next;
	assign rd_phase = phase_next;

	assign start = (state == sc_latch);
	assign m_latch = (state == sc_latch);
	assign m_clk = (state == sc_clk_hi);
	assign m_oe = !((state == sc_wait) && lit);

	a_latch_clk: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		!(m_latch && m_clk))
		else $error("m_latch and m_clk high together");

	a_lit_in_wait: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		lit |-> state == sc_wait)
		else $error("lit window outside WAIT");

endmodule

// ==== verilog/phase_timer.sv ====
module phase_timer (
	input logic display_driver_clk,
	input logic arst_n,
	input logic start,
	input matrix_pkg::phase_t phase,
	input logic [7:0] brightness,
	output logic lit,
	output logic done
);
	import matrix_pkg::*;

	logic [cnt_w-1:0] period_cnt;
	logic [cnt_w-1:0] lit_cnt;
	logic [7:0] lit_exp;

	// lit length is 2^(brightness+phase)
	assign lit_exp = brightness + 8'(phase);

	always_ff @(posedge display_driver_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			period_cnt <= '0;
			lit_cnt <= '0;
		end
		else if (start)
		begin
			period_cnt <= phase_period[phase];
			lit_cnt <= {{(cnt_w-1){1'b0}}, 1'b1} << lit_exp;
		end
		else
		begin
			if (period_cnt != '0)
				period_cnt <= period_cnt - 1'b1;
			if (lit_cnt != '0)
				lit_cnt <= lit_cnt - 1'b1;
		end
	end

	assign lit = (lit_cnt != '0);
	// last cycle of the period
	assign done = (period_cnt == cnt_w'(1));

	a_start_idle: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		start |-> period_cnt == '0)
		else $error("phase start while timer busy");

endmodule

// ==== verilog/matrix_driver.sv ====
module matrix_driver (
	input logic display_driver_clk,
	input logic arst_n,
	input logic [7:0] input_byte,
	output logic [matrix_pkg::addr_w-1:0] mem_addr,
	output logic ramclk,
	output logic [matrix_pkg::line_w-1:0] m_line_addr,
	output logic m_r1,
	output logic m_g1,
	output logic m_b1,
	output logic m_r2,
	output logic m_g2,
	output logic m_b2,
	output logic m_latch,
	output logic m_oe,
	output logic m_clk
);
	import matrix_pkg::*;

	logic wr_en;
	logic [pix_w-1:0] wr_addr;
	logic [5:0] wr_upper;
	logic [5:0] wr_lower;
	logic [7:0] brightness;
	logic [line_w-1:0] rd_line;
	logic [col_w-1:0] rd_col;
	phase_t rd_phase;
	logic r1, g1, b1, r2, g2, b2;
	logic start, lit, done;

	frame_loader frame_loader_inst (
		.display_driver_clk(display_driver_clk),
		.arst_n(arst_n),
		.input_byte(input_byte),
		.mem_addr(mem_addr),
		.ramclk(ramclk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_upper(wr_upper),
		.wr_lower(wr_lower),
		.brightness(brightness)
	);

	frame_buffer frame_buffer_inst (
		.display_driver_clk(display_driver_clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_upper(wr_upper),
		.wr_lower(wr_lower),
		.rd_line(rd_line),
		.rd_col(rd_col),
		.rd_phase(rd_phase),
		.r1(r1), .g1(g1), .b1(b1),
		.r2(r2), .g2(g2), .b2(b2)
	);

	scan_sequencer scan_sequencer_inst (
		.display_driver_clk(display_driver_clk),
		.arst_n(arst_n),
		.r1(r1), .g1(g1), .b1(b1),
		.r2(r2), .g2(g2), .b2(b2),
		.lit(lit),
		.done(done),
		.rd_line(rd_line),
		.rd_col(rd_col),
		.rd_phase(rd_phase),
		.start(start),
		.m_line_addr(m_line_addr),
		.m_r1(m_r1), .m_g1(m_g1), .m_b1(m_b1),
		.m_r2(m_r2), .m_g2(m_g2), .m_b2(m_b2),
		.m_latch(m_latch),
		.m_oe(m_oe),
		.m_clk(m_clk)
	);

	phase_timer phase_timer_inst (
		.display_driver_clk(display_driver_clk),
		.arst_n(arst_n),
		.start(start),
		.phase(rd_phase),
		.brightness(brightness),
		.lit(lit),
		.done(done)
	);

endmodule

// ==== tests/matrix_driver_tb.sv ====
module matrix_driver_tb;
	import matrix_pkg::*;

	logic display_driver_clk;
	logic arst_n;
	logic [7:0] input_byte;
	logic [addr_w-1:0] mem_addr;
	logic ramclk;
	logic [line_w-1:0] m_line_addr;
	logic m_r1, m_g1, m_b1, m_r2, m_g2, m_b2;
	logic m_latch, m_oe, m_clk;

	// pixel bytes below 0x0800 and the brightness byte at 0x0800
	logic [7:0] mem [0:4095];
	integer seed;
	integer errors;
	integer base_errors;
	integer tests_run;
	logic timed_out;
	logic [7:0] exp_bright;
	logic bright_known;

	logic ramclk_q;
	logic [11:0] read_idx;
	integer reads_total;
	integer bright_reads;

	logic m_clk_q;
	integer clk_count;
	integer latch_count;
	integer cur_line;
	integer cur_phase;
	integer oe_low;
	integer since_latch;
	integer exp_lit;
	integer exp_period;
	logic lit_armed;

	matrix_driver matrix_driver_inst (.*);

	initial
	begin
		display_driver_clk = 1'b0;
		forever
			#50 display_driver_clk = ~display_driver_clk;
	end

	// memory answers from the address on every falling edge
	initial
	begin
		input_byte = 8'h00;
		forever
		begin
			@(negedge display_driver_clk);
			input_byte = mem[mem_addr[11:0]];
		end
	end

	function automatic logic [addr_w-1:0] expected_addr(input logic [11:0] idx);
		if (idx == 12'd0)
			expected_addr = brightness_addr;
		else if (idx[0])
			expected_addr = upper_base + 16'((idx - 12'd1) >> 1);
		else
			expected_addr = lower_base + 16'((idx - 12'd2) >> 1);
	endfunction

	function automatic logic plane_of(input logic [1:0] comp, input integer ph);
		if (ph == 0)
			plane_of = comp[0];
		else if (ph == 1)
			plane_of = comp[1];
		else
			plane_of = comp[0] & comp[1];
	endfunction

	function automatic logic [5:0] expected_rgb(input integer ln, input integer col,
		input integer ph);
		logic [7:0] up;
		logic [7:0] lo;
		up = mem[12'(ln * num_cols + col)];
		lo = mem[12'(32'(lower_base) + ln * num_cols + col)];
		expected_rgb = {plane_of(up[1:0], ph), plane_of(up[3:2], ph), plane_of(up[5:4], ph),
			plane_of(lo[1:0], ph), plane_of(lo[3:2], ph), plane_of(lo[5:4], ph)};
	endfunction

	function automatic integer counter_value(input integer kind);
		case (kind)
			0: counter_value = reads_total;
			1: counter_value = bright_reads;
			default: counter_value = latch_count;
		endcase
	endfunction

	task automatic report_error(input string msg);
		errors = errors + 1;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	task automatic close_test(input string name);
		if (timed_out)
			$display("%s: aborted after timeout", name);
		else
		begin
			tests_run = tests_run + 1;
			$display("%s: %0d errors", name, errors - base_errors);
		end
		base_errors = errors;
	endtask

	task automatic wait_for_count(input integer kind, input integer target, input integer limit,
		input string what);
		integer cycles;
		integer now;
		cycles = 0;
		now = counter_value(kind);
		while (now < target && !timed_out)
		begin
			@(negedge display_driver_clk);
			cycles = cycles + 1;
			if (cycles > limit)
			begin
				$display("timeout: no progress on %s after %0d cycles", what, limit);
				timed_out = 1'b1;
			end
			now = counter_value(kind);
		end
	endtask

	task automatic load_brightness(input logic [7:0] value);
		integer target;
		@(negedge display_driver_clk);
		bright_known = 1'b0;
		@(posedge display_driver_clk);
		mem[12'(brightness_addr)] = value;
		target = bright_reads + 2;
		wait_for_count(1, target, 25000, "brightness reads");
		// only 1 to 8 is taken
		if (value >= 8'd1 && value <= 8'd8)
			exp_bright = value;
		bright_known = 1'b1;
		wait_for_count(2, latch_count + 4, 4 * 2300, "latches after brightness change");
	endtask

	always @(posedge display_driver_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ramclk_q <= 1'b0;
			read_idx <= 12'd0;
			reads_total <= 0;
			bright_reads <= 0;
		end
		else
		begin
			ramclk_q <= ramclk;
			if (ramclk && !ramclk_q)
			begin
				read_idx <= (read_idx == 12'd2048) ? 12'd0 : read_idx + 12'd1;
				reads_total <= reads_total + 1;
				if (mem_addr == brightness_addr)
					bright_reads <= bright_reads + 1;
			end
		end
	end

	always @(posedge display_driver_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			m_clk_q <= 1'b0;
			clk_count <= 0;
			latch_count <= 0;
			cur_line <= 0;
			cur_phase <= 0;
			oe_low <= 0;
			since_latch <= 0;
			exp_lit <= 0;
			exp_period <= 0;
			lit_armed <= 1'b0;
		end
		else
		begin
			m_clk_q <= m_clk;
			if (m_clk && !m_clk_q)
				clk_count <= clk_count + 1;
			if (m_latch)
			begin
				clk_count <= 0;
				latch_count <= latch_count + 1;
				oe_low <= 0;
				since_latch <= 0;
				exp_lit <= 1 << (32'(exp_bright) + cur_phase);
				exp_period <= 512 << cur_phase;
				lit_armed <= bright_known;
				// next shift belongs to the following phase
				if (cur_phase == 2)
				begin
					cur_phase <= 0;
					cur_line <= (cur_line == num_lines - 1) ? 0 : cur_line + 1;
				end
				else
					cur_phase <= cur_phase + 1;
			end
			else
			begin
				since_latch <= since_latch + 1;
				if (!m_oe)
					oe_low <= oe_low + 1;
			end
		end
	end

	a_reset_state: assert property (@(posedge display_driver_clk)
		!arst_n |-> !ramclk && !m_clk && !m_latch && m_oe)
		else report_error("outputs not idle during reset");

	a_read_addr: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		(ramclk && !ramclk_q) |-> mem_addr == expected_addr(read_idx))
		else report_error("read address out of order");

	a_addr_hold: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		ramclk |-> $stable(mem_addr))
		else report_error("mem_addr moved while ramclk high");

	a_shift_count: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		m_latch |-> clk_count == num_cols)
		else report_error("wrong number of m_clk pulses before latch");

	a_line_addr: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		m_latch |-> 32'(m_line_addr) == cur_line)
		else report_error("m_line_addr wrong at latch");

	a_pixel: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		(m_clk && !m_clk_q && bright_reads >= 2)
		|-> {m_r1, m_g1, m_b1, m_r2, m_g2, m_b2} == expected_rgb(cur_line, clk_count, cur_phase))
		else report_error("colour outputs differ from memory byte plane");

	a_lit_time: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		(m_latch && lit_armed) |-> oe_low == exp_lit)
		else report_error("m_oe low time wrong");

	a_period: assert property (@(posedge display_driver_clk) disable iff (!arst_n)
		m_latch |-> since_latch >= exp_period)
		else report_error("latch before end of phase period");

	initial
	begin
		seed = 32'h80b1;
		errors = 0;
		base_errors = 0;
		tests_run = 0;
		timed_out = 1'b0;
		arst_n = 1'b1;
		exp_bright = brightness_reset;
		bright_known = 1'b1;
		for (int i = 0; i < 2048; i++)
			mem[12'(i)] = 8'($random(seed));
		// brightness byte out of range so the reset value stays
		mem[12'(brightness_addr)] = 8'h00;

		@(negedge display_driver_clk);
		arst_n = 1'b0;
		repeat (2) @(posedge display_driver_clk);
		@(negedge display_driver_clk);
		arst_n = 1'b1;

		wait_for_count(0, 5, 100, "first memory reads");
		close_test("reset and first reads");
		wait_for_count(1, 2, 20000, "second brightness read");
		close_test("read protocol");
		wait_for_count(2, latch_count + 49, 49 * 2300, "line wrap latches");
		close_test("shift and latch");
		wait_for_count(2, latch_count + 6, 6 * 2300, "pixel latches");
		close_test("pixel data");
		wait_for_count(2, latch_count + 3, 3 * 2300, "lit latches");
		close_test("lit time");
		load_brightness(8'd2);
		load_brightness(8'd9);
		load_brightness(8'd5);
		close_test("brightness update");

		$display("tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0 && !timed_out)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
verilog/matrix_pkg.sv
verilog/frame_loader.sv
verilog/frame_buffer.sv
verilog/scan_sequencer.sv
verilog/phase_timer.sv
verilog/matrix_driver.sv
tests/matrix_driver_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module matrix_driver_tb \
	-o matrix_driver_sim
./obj_dir/matrix_driver_sim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
